// File: design/vdp_config.svh
// timing and register map constants for a 640x480 display
// pixel clock assumed at the nominal 25.175 MHz rate, no widescreen mode
`ifndef VDP_CONFIG_SVH
`define VDP_CONFIG_SVH

// horizontal timing in clocks, offscreen area comes first in each line
`define VDP_H_ACTIVE         640
`define VDP_H_FRONTPORCH     16
`define VDP_H_SYNC           96
`define VDP_H_BACKPORCH      48
`define VDP_H_OFFSCREEN      (`VDP_H_FRONTPORCH + `VDP_H_SYNC + `VDP_H_BACKPORCH)
`define VDP_H_TOTAL          (`VDP_H_OFFSCREEN + `VDP_H_ACTIVE)

// vertical timing in lines, active area comes first in each frame
`define VDP_V_ACTIVE         480
`define VDP_V_FRONTPORCH     11
`define VDP_V_SYNC           2
`define VDP_V_BACKPORCH      31
`define VDP_V_TOTAL          (`VDP_V_ACTIVE + `VDP_V_FRONTPORCH + `VDP_V_SYNC + `VDP_V_BACKPORCH)

// raster_x low bits that carry the host write
`define VDP_VRAM_SLOT_PHASE  7

// write registers
`define VDP_REG_PALETTE_ADDR 0
`define VDP_REG_PALETTE_DATA 1
`define VDP_REG_VRAM_ADDR    2
`define VDP_REG_VRAM_DATA    3
`define VDP_REG_VRAM_INCR    4

// read registers
`define VDP_REG_RASTER_X     0
`define VDP_REG_RASTER_Y     1

// widths
`define VDP_RASTER_X_WIDTH      12
`define VDP_RASTER_Y_WIDTH      11
`define VDP_DATA_WIDTH          16
`define VDP_PALETTE_ADDR_WIDTH  8
`define VDP_VRAM_ADDR_WIDTH     14
`define VDP_VRAM_INCR_WIDTH     8
`define VDP_COLOR_CHANNEL_WIDTH 4

`endif

// File: design/vdp_host_registers.sv
// host register port, writes act on the next clock
// a vram data write must wait for host_ready, the data register holds one word
// reads return data one cycle after host_read_en and hold it until the next read
`timescale 1ns/10ps
`include "vdp_config.svh"

module vdp_host_registers (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   host_write_en,
    input  logic                   host_read_en,
    input  logic [15:0]            host_address,
    input  logic [15:0]            host_write_data,
    input  vdp_pkg::raster_x_t     raster_x,
    input  vdp_pkg::raster_y_t     raster_y,
    input  logic                   vram_written,
    output logic [15:0]            host_read_data,
    output logic                   host_ready,
    output vdp_pkg::palette_write_t palette_write,
    output vdp_pkg::vram_request_t vram_request
);
    import vdp_pkg::*;

    logic [`VDP_PALETTE_ADDR_WIDTH-1:0] palette_address;
    // byte address, bit 0 picks the lane
    logic [`VDP_VRAM_ADDR_WIDTH:0]      vram_byte_address;
    logic [`VDP_VRAM_INCR_WIDTH-1:0]    vram_increment;
    logic [`VDP_DATA_WIDTH-1:0]         vram_data;
    logic                               vram_lane;
    logic                               vram_pending;
    logic                               palette_data_write;
    logic                               vram_data_write;

    assign palette_data_write = host_write_en
        && host_address == 16'(`VDP_REG_PALETTE_DATA);
    assign vram_data_write = host_write_en && host_address == 16'(`VDP_REG_VRAM_DATA);

    // palette ram writes at the current address on this clock
    assign palette_write = palette_write_t'{
        address: palette_address,
        data: host_write_data,
        enable: palette_data_write
    };

    assign vram_request = vram_request_t'{
        word_address: vram_byte_address[`VDP_VRAM_ADDR_WIDTH:1],
        odd: vram_lane,
        data: vram_data,
        pending: vram_pending
    };

    assign host_ready = !vram_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            palette_address <= '0;
            vram_byte_address <= '0;
            // step of one byte until the host sets another
            vram_increment <= `VDP_VRAM_INCR_WIDTH'(1);
            vram_pending <= 1'b0;
        end else begin
            if (vram_written) begin
                vram_pending <= 1'b0;
                vram_byte_address <= vram_byte_address + (`VDP_VRAM_ADDR_WIDTH + 1)'(vram_increment);
            end
            if (palette_data_write) begin
                palette_address <= palette_address + 1'b1;
            end
            if (host_write_en) begin
                case (host_address)
                    16'(`VDP_REG_PALETTE_ADDR):
                        palette_address <= host_write_data[`VDP_PALETTE_ADDR_WIDTH-1:0];
                    16'(`VDP_REG_VRAM_ADDR):
                        vram_byte_address <= host_write_data[`VDP_VRAM_ADDR_WIDTH:0];
                    16'(`VDP_REG_VRAM_DATA):
                        vram_pending <= 1'b1;
                    16'(`VDP_REG_VRAM_INCR):
                        vram_increment <= host_write_data[`VDP_VRAM_INCR_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // word and lane for the slot
    always_ff @(posedge clk) begin
        if (vram_data_write) begin
            vram_data <= host_write_data;
            vram_lane <= vram_byte_address[0];
        end
    end

    always_ff @(posedge clk) begin
        if (host_read_en) begin
            case (host_address)
                16'(`VDP_REG_RASTER_X): host_read_data <= 16'(raster_x);
                16'(`VDP_REG_RASTER_Y): host_read_data <= 16'(raster_y);
                default: host_read_data <= '0;
            endcase
        end
    end

    // the slot module has not taken the previous word yet
    a_no_data_write_while_pending: assert property (@(posedge clk) disable iff (reset)
        vram_data_write |-> !vram_pending);

endmodule

// File: design/vdp_palette_output.sv
// 256-entry palette, only entry 0 is read back as the backdrop
// rgb trails active_display by two clocks and is black outside it
`timescale 1ns/10ps
`include "vdp_config.svh"

module vdp_palette_output (
    input  logic                    clk,
    input  vdp_pkg::palette_write_t palette_write,
    input  logic                    active_display,
    output vdp_pkg::color_t         rgb
);
    import vdp_pkg::*;

    localparam int PALETTE_DEPTH = 1 << `VDP_PALETTE_ADDR_WIDTH;

    logic [`VDP_DATA_WIDTH-1:0] palette_ram [PALETTE_DEPTH];
    logic [`VDP_DATA_WIDTH-1:0] backdrop_word;
    logic                       active_delayed;
    color_t                     backdrop_color;

    always_ff @(posedge clk) begin
        if (palette_write.enable) begin
            palette_ram[palette_write.address] <= palette_write.data;
        end
        backdrop_word <= palette_ram[0];
    end

    // upper nibble of the palette word is not displayed
    assign backdrop_color = backdrop_word[$bits(color_t)-1:0];

    // active_display delayed to meet the palette read
    always_ff @(posedge clk) begin
        active_delayed <= active_display;
        rgb <= active_delayed ? backdrop_color : '0;
    end

endmodule

// File: design/vdp_pkg.sv
// shared types of the display controller
// vram addresses are 16-bit word addresses, one bank per lane
`include "vdp_config.svh"

package vdp_pkg;

    typedef logic [`VDP_RASTER_X_WIDTH-1:0] raster_x_t;
    typedef logic [`VDP_RASTER_Y_WIDTH-1:0] raster_y_t;

    // 12-bit output color, red in the top nibble
    typedef struct packed {
        logic [`VDP_COLOR_CHANNEL_WIDTH-1:0] r;
        logic [`VDP_COLOR_CHANNEL_WIDTH-1:0] g;
        logic [`VDP_COLOR_CHANNEL_WIDTH-1:0] b;
    } color_t;

    typedef struct packed {
        logic [`VDP_PALETTE_ADDR_WIDTH-1:0] address;
        logic [`VDP_DATA_WIDTH-1:0]         data;
        logic                               enable;
    } palette_write_t;

    // host write waiting for its vram slot
    typedef struct packed {
        logic [`VDP_VRAM_ADDR_WIDTH-1:0] word_address;
        logic                            odd;
        logic [`VDP_DATA_WIDTH-1:0]      data;
        logic                            pending;
    } vram_request_t;

    typedef struct packed {
        logic [`VDP_VRAM_ADDR_WIDTH-1:0] address;
        logic                            we;
        logic [`VDP_DATA_WIDTH-1:0]      write_data;
    } vram_port_t;

endpackage

// File: design/vdp_top.sv
// tile display controller core, backdrop color only
// vram read data inputs are reserved for the render path and ignored here
`timescale 1ns/10ps

module vdp_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [15:0]         host_address,
    input  logic [15:0]         host_write_data,
    input  logic                host_write_en,
    input  logic                host_read_en,
    output logic [15:0]         host_read_data,
    output logic                host_ready,
    output vdp_pkg::color_t     rgb,
    output logic                hsync,
    output logic                vsync,
    output logic                active_display,
    output logic                line_ended,
    output logic                frame_ended,
    output vdp_pkg::vram_port_t vram_even,
    output vdp_pkg::vram_port_t vram_odd,
    input  logic [15:0]         vram_read_data_even,
    input  logic [15:0]         vram_read_data_odd
);
    import vdp_pkg::*;

    raster_x_t      raster_x;
    raster_y_t      raster_y;
    palette_write_t palette_write;
    vram_request_t  vram_request;
    logic           vram_written;

    vdp_video_timing video_timing_inst (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .hsync(hsync),
        .vsync(vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended)
    );

    vdp_host_registers host_registers_inst (
        .clk(clk),
        .reset(reset),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .vram_written(vram_written),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .palette_write(palette_write),
        .vram_request(vram_request)
    );

    vdp_vram_slot vram_slot_inst (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .vram_request(vram_request),
        .vram_written(vram_written),
        .vram_even(vram_even),
        .vram_odd(vram_odd)
    );

    vdp_palette_output palette_output_inst (
        .clk(clk),
        .palette_write(palette_write),
        .active_display(active_display),
        .rgb(rgb)
    );

endmodule

// File: design/vdp_video_timing.sv
// 640x480 raster timing, offscreen columns precede the active ones
// syncs are active low, strobes are single-cycle and not meant for the monitor
`timescale 1ns/10ps
`include "vdp_config.svh"

module vdp_video_timing (
    input  logic               clk,
    input  logic               reset,
    output vdp_pkg::raster_x_t raster_x,
    output vdp_pkg::raster_y_t raster_y,
    output logic               hsync,
    output logic               vsync,
    output logic               active_display,
    output logic               line_ended,
    output logic               frame_ended
);
    import vdp_pkg::*;

    localparam raster_x_t X_LAST = raster_x_t'(`VDP_H_TOTAL - 1);
    localparam raster_y_t Y_LAST = raster_y_t'(`VDP_V_TOTAL - 1);
    localparam raster_x_t HSYNC_START = raster_x_t'(`VDP_H_FRONTPORCH);
    localparam raster_x_t HSYNC_END = raster_x_t'(`VDP_H_FRONTPORCH + `VDP_H_SYNC - 1);
    localparam raster_y_t VSYNC_START = raster_y_t'(`VDP_V_ACTIVE + `VDP_V_FRONTPORCH);
    localparam raster_y_t VSYNC_END = raster_y_t'(`VDP_V_ACTIVE + `VDP_V_FRONTPORCH + `VDP_V_SYNC - 1);

    raster_x_t x_next;
    raster_y_t y_next;

    always_comb begin
        x_next = raster_x + 1'b1;
        y_next = raster_y;
        if (raster_x == X_LAST) begin
            x_next = '0;
            y_next = (raster_y == Y_LAST) ? '0 : raster_y + 1'b1;
        end
    end

    // syncs and strobes decoded from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            active_display <= 1'b0;
            line_ended <= 1'b0;
            frame_ended <= 1'b0;
        end else begin
            raster_x <= x_next;
            raster_y <= y_next;
            hsync <= !(x_next >= HSYNC_START && x_next <= HSYNC_END);
            vsync <= !(y_next >= VSYNC_START && y_next <= VSYNC_END);
            // one cycle behind the counters, the palette read makes up the rest
            active_display <= (raster_x >= raster_x_t'(`VDP_H_OFFSCREEN))
                && (raster_y < raster_y_t'(`VDP_V_ACTIVE));
            line_ended <= (x_next == X_LAST);
            frame_ended <= (x_next == X_LAST) && (y_next == Y_LAST);
        end
    end

    a_raster_x_in_line: assert property (@(posedge clk) disable iff (reset)
        raster_x <= X_LAST);

    a_frame_end_on_line_end: assert property (@(posedge clk) disable iff (reset)
        frame_ended |-> line_ended && raster_y == Y_LAST);

endmodule

// File: design/vdp_vram_slot.sv
// vram access schedule reduced to the host write slot, one in every 8 clocks
// read data from the banks is not consumed here
`timescale 1ns/10ps
`include "vdp_config.svh"

module vdp_vram_slot (
    input  logic                   clk,
    input  logic                   reset,
    input  vdp_pkg::raster_x_t     raster_x,
    input  vdp_pkg::vram_request_t vram_request,
    output logic                   vram_written,
    output vdp_pkg::vram_port_t    vram_even,
    output vdp_pkg::vram_port_t    vram_odd
);
    import vdp_pkg::*;

    logic       host_slot;
    vram_port_t even_next;
    vram_port_t odd_next;

    assign host_slot = raster_x[2:0] == 3'(`VDP_VRAM_SLOT_PHASE);

    // accept pulse, the register port clears pending on this edge
    assign vram_written = host_slot && vram_request.pending;

    always_comb begin
        even_next.address = vram_request.word_address;
        even_next.write_data = vram_request.data;
        even_next.we = vram_written && !vram_request.odd;

        // same word on both banks, only the lane's we is raised
        odd_next.address = vram_request.word_address;
        odd_next.write_data = vram_request.data;
        odd_next.we = vram_written && vram_request.odd;
    end

    always_ff @(posedge clk) begin
        vram_even <= even_next;
        vram_odd <= odd_next;
        if (reset) begin
            vram_even.we <= 1'b0;
            vram_odd.we <= 1'b0;
        end
    end

    a_single_lane_write: assert property (@(posedge clk) disable iff (reset)
        !(vram_even.we && vram_odd.we));

endmodule

// File: flist.f
+incdir+design
design/vdp_pkg.sv
design/vdp_video_timing.sv
design/vdp_host_registers.sv
design/vdp_vram_slot.sv
design/vdp_palette_output.sv
design/vdp_top.sv
verification/vdp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the display controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f flist.f --top-module vdp_tb -o vdp_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/vdp_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    exit 1
fi
exit 0

// File: verification/vdp_tb.sv
// testbench for the backdrop-only display controller core
// runs a little over two frames at the config header timing
// random payloads from $urandom with seed 24
`timescale 1ns/10ps
`include "vdp_config.svh"

module vdp_tb;
    import vdp_pkg::*;

    typedef struct packed {
        logic       odd;
        vram_port_t port;
        color_t     color;
    } expected_t;

    localparam int LINE_CYCLES = `VDP_H_TOTAL;
    localparam int FRAME_LINES = `VDP_V_TOTAL;

    logic        clk = 1'b0;
    logic        reset;
    logic [15:0] host_address;
    logic [15:0] host_write_data;
    logic        host_write_en;
    logic        host_read_en;
    logic [15:0] host_read_data;
    logic        host_ready;
    color_t      rgb;
    logic        hsync;
    logic        vsync;
    logic        active_display;
    logic        line_ended;
    logic        frame_ended;
    vram_port_t  vram_even;
    vram_port_t  vram_odd;
    logic [15:0] vram_read_data_even;
    logic [15:0] vram_read_data_odd;

    int          error_count = 0;
    int          rgb_mismatches = 0;
    int          rgb_checks = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_before_test = 0;
    logic        backdrop_check = 1'b0;
    logic [15:0] backdrop_word = '0;
    logic [2:0]  active_history = '0;

    vdp_top vdp_top_inst (.*);

    always #2 clk = ~clk;

    // expected bank write and backdrop color from the register model
    function automatic expected_t vdp_expected(input logic [14:0] byte_address,
            input logic [15:0] data, input logic [15:0] palette_entry, input logic shown);
        expected_t e;
        e.odd = byte_address[0];
        e.port.address = byte_address[14:1];
        e.port.we = 1'b1;
        e.port.write_data = data;
        e.color = shown ? color_t'(palette_entry[11:0]) : color_t'(0);
        return e;
    endfunction

    // rgb trails active_display by two clocks, compare only where the history is settled
    always @(negedge clk) begin
        expected_t e;
        active_history = {active_history[1:0], active_display};
        if (backdrop_check && (active_history == 3'b111 || active_history == 3'b000)) begin
            e = vdp_expected('0, '0, backdrop_word, active_history[0]);
            if (active_history[0]) rgb_checks++;
            assert (rgb == e.color) else begin
                $display("mismatch backdrop rgb: expected %h actual %h", e.color, rgb);
                rgb_mismatches++;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        error_count++;
    endtask

    task automatic finish_test(input string name);
        int failures;
        failures = error_count + rgb_mismatches - errors_before_test;
        if (failures == 0) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, failures);
            tests_failed++;
        end
        errors_before_test = error_count + rgb_mismatches;
    endtask

    task automatic write_register(input int index, input logic [15:0] data);
        @(posedge clk);
        host_write_en <= 1'b1;
        host_address <= 16'(index);
        host_write_data <= data;
        @(posedge clk);
        host_write_en <= 1'b0;
    endtask

    // data is captured on the clock after host_read_en
    task automatic read_register(input int index, output logic [15:0] data);
        @(posedge clk);
        host_read_en <= 1'b1;
        host_address <= 16'(index);
        @(posedge clk);
        host_read_en <= 1'b0;
        @(negedge clk);
        data = host_read_data;
    endtask

    task automatic wait_line_end(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!line_ended && cycles < 2 * LINE_CYCLES);
        if (!line_ended) report_timeout("line_ended");
    endtask

    task automatic wait_frame_end(output int cycles, output int lines,
            output int active_cycles, output int vsync_low_cycles);
        cycles = 0;
        lines = 0;
        active_cycles = 0;
        vsync_low_cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (line_ended) lines++;
            if (active_display) active_cycles++;
            if (!vsync) vsync_low_cycles++;
        end while (!frame_ended && cycles < 2 * LINE_CYCLES * FRAME_LINES);
        if (!frame_ended) report_timeout("frame_ended");
    endtask

    task automatic wait_vram_write(output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 10) begin
            @(negedge clk);
            cycles++;
            seen = vram_even.we || vram_odd.we;
        end
        if (!seen) report_timeout("a vram write enable");
    endtask

    task automatic wait_host_ready();
        int cycles;
        cycles = 0;
        while (!host_ready && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!host_ready) report_timeout("host_ready");
    endtask

    // called at the negedge where a we is high
    task automatic check_vram_write(input string name, input logic [14:0] byte_address,
            input logic [15:0] data);
        expected_t  e;
        vram_port_t lane_port;
        e = vdp_expected(byte_address, data, '0, 1'b0);
        lane_port = e.odd ? vram_odd : vram_even;
        check_value({name, " odd we"}, 32'(e.odd), 32'(vram_odd.we));
        check_value({name, " even we"}, 32'(!e.odd), 32'(vram_even.we));
        check_value({name, " word address"}, 32'(e.port.address), 32'(lane_port.address));
        check_value({name, " even data"}, 32'(e.port.write_data), 32'(vram_even.write_data));
        check_value({name, " odd data"}, 32'(e.port.write_data), 32'(vram_odd.write_data));
        @(negedge clk);
        check_value({name, " we after pulse"}, 0, 32'({vram_even.we, vram_odd.we}));
        check_value({name, " host_ready"}, 1, 32'(host_ready));
    endtask

    initial begin
        int          cycles;
        int          lines;
        int          active_cycles;
        int          vsync_low_cycles;
        int          low_cycles;
        int          gap;
        logic        seen;
        logic [14:0] byte_address;
        logic [15:0] data;
        logic [15:0] first_word;
        logic [7:0]  increment;
        logic [15:0] first_read;
        logic [15:0] second_read;

        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        vram_read_data_even = '0;
        vram_read_data_odd = '0;
        first_word = '0;
        void'($urandom(24));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        check_value("reset even we", 0, 32'(vram_even.we));
        check_value("reset odd we", 0, 32'(vram_odd.we));
        check_value("reset rgb", 0, 32'(rgb));
        check_value("reset host_ready", 1, 32'(host_ready));
        check_value("reset line_ended", 0, 32'(line_ended));
        check_value("reset frame_ended", 0, 32'(frame_ended));
        finish_test("reset");

        wait_line_end(cycles);
        wait_line_end(cycles);
        check_value("timing line period", LINE_CYCLES, cycles);
        // right after line_ended the sync is still high
        cycles = 0;
        while (hsync && cycles < 2 * LINE_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (hsync) report_timeout("hsync low");
        low_cycles = 0;
        while (!hsync && low_cycles < 2 * LINE_CYCLES) begin
            @(negedge clk);
            low_cycles++;
        end
        check_value("timing hsync low time", `VDP_H_SYNC, low_cycles);
        wait_frame_end(cycles, lines, active_cycles, vsync_low_cycles);
        wait_frame_end(cycles, lines, active_cycles, vsync_low_cycles);
        check_value("timing frame lines", FRAME_LINES, lines);
        check_value("timing frame cycles", LINE_CYCLES * FRAME_LINES, cycles);
        check_value("timing active cycles", `VDP_H_ACTIVE * `VDP_V_ACTIVE, active_cycles);
        check_value("timing vsync low cycles", LINE_CYCLES * `VDP_V_SYNC, vsync_low_cycles);
        finish_test("timing");

        // the frame has just wrapped, so the next lines are active
        write_register(`VDP_REG_PALETTE_ADDR, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            data = 16'($urandom);
            if (i == 0) first_word = data;
            write_register(`VDP_REG_PALETTE_DATA, data);
        end
        backdrop_word = first_word;
        repeat (3) @(posedge clk);
        backdrop_check = 1'b1;
        wait_line_end(cycles);
        wait_line_end(cycles);
        backdrop_check = 1'b0;
        check_value("palette backdrop compares made", 1, 32'(rgb_checks > 0));
        finish_test("palette");

        byte_address = 15'($urandom);
        data = 16'($urandom);
        write_register(`VDP_REG_VRAM_ADDR, 16'(byte_address));
        write_register(`VDP_REG_VRAM_DATA, data);
        wait_vram_write(seen);
        if (seen) check_vram_write("single write", byte_address, data);
        finish_test("vram_single");

        increment = 8'(($urandom % 255) + 1);
        byte_address = 15'($urandom);
        write_register(`VDP_REG_VRAM_INCR, 16'(increment));
        write_register(`VDP_REG_VRAM_ADDR, 16'(byte_address));
        for (int i = 0; i < 6; i++) begin
            wait_host_ready();
            data = 16'($urandom);
            write_register(`VDP_REG_VRAM_DATA, data);
            wait_vram_write(seen);
            if (seen) check_vram_write("auto increment", byte_address, data);
            byte_address = byte_address + 15'(increment);
        end
        finish_test("vram_increment");

        // start of a line so both x reads stay within it
        wait_line_end(cycles);
        gap = 2 + int'($urandom % 60);
        read_register(`VDP_REG_RASTER_X, first_read);
        repeat (gap - 2) @(posedge clk);
        read_register(`VDP_REG_RASTER_X, second_read);
        check_value("raster x step", 32'(first_read) + 32'(gap), 32'(second_read));
        read_register(`VDP_REG_RASTER_Y, first_read);
        wait_line_end(cycles);
        read_register(`VDP_REG_RASTER_Y, second_read);
        check_value("raster y step", (32'(first_read) + 1) % FRAME_LINES, 32'(second_read));
        finish_test("raster_readback");

        $display("tests passed %0d failed %0d, error count %0d",
            tests_passed, tests_failed, error_count + rgb_mismatches);
        if (tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
